//--- design/term_pkg.sv
`default_nettype none

package term_pkg;

    // Text grid and glyph size
    localparam int COLS    = 16;
    localparam int ROWS    = 8;
    localparam int GLYPH_W = 8;
    localparam int GLYPH_H = 8;

    // Raster timing in pixel clocks and lines
    localparam int H_ACTIVE     = 128;
    localparam int H_TOTAL      = 160;
    localparam int V_ACTIVE     = 64;
    localparam int V_TOTAL      = 72;
    localparam int H_SYNC_START = 136;
    localparam int H_SYNC_LEN   = 8;
    localparam int V_SYNC_START = 66;
    localparam int V_SYNC_LEN   = 2;
    localparam int PIPE_LAT     = 3;     // Counter to pixel register

    localparam int CLKS_PER_BIT = 16;    // Serial bit time in clocks
    localparam int BELL_CYCLES  = 23040; // Two whole frames
    localparam logic [7:0] CLEAR_CHAR = 8'h20;

    typedef logic [7:0]  char_t;
    typedef logic [3:0]  col_t;
    typedef logic [2:0]  row_t;
    typedef logic [6:0]  vram_addr_t;  // {row, col}
    typedef logic [10:0] font_addr_t;  // {char, glyph line}
    typedef logic [7:0]  font_row_t;   // Leftmost pixel in MSB
    typedef logic [15:0] rgb_t;        // RGB565

    typedef struct packed {
        rgb_t rgb;
        logic hsync;
        logic vsync;
        logic den;
    } lcd_out_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    typedef enum logic [1:0] {CT_CLEAR_ALL, CT_IDLE, CT_WRITE, CT_CLEAR_ROW} ctrl_state_t;

endpackage

`default_nettype wire

//--- design/serial_rx.sv
`timescale 1ns/1ns
`default_nettype none

module serial_rx (
    input  wire logic            i_clk,
    input  wire logic            i_arst_n,
    input  wire logic            i_rxd,     // Idles high, 8N1
    input  wire logic            i_ready,
    output logic                 o_valid,
    output term_pkg::char_t      o_char,
    output logic                 o_overrun  // One-clock pulse on a dropped byte
);

    typedef logic [$clog2(term_pkg::CLKS_PER_BIT)-1:0] tick_t;

    logic                rxd_meta, rxd_sync;  // Two-flop synchronizer
    term_pkg::rx_state_t state;
    tick_t               tick_cnt;            // Clocks since last sample point
    logic [2:0]          bit_idx;             // Data bit being sampled
    term_pkg::char_t     shift_reg;           // Byte being assembled
    logic                mid_bit;
    logic                end_bit;
    logic                stop_ok;
    logic                load;

    assign mid_bit = (tick_cnt == tick_t'(term_pkg::CLKS_PER_BIT / 2 - 1));
    assign end_bit = (tick_cnt == tick_t'(term_pkg::CLKS_PER_BIT - 1));
    assign stop_ok = (state == term_pkg::RX_STOP) && end_bit && rxd_sync; // Valid framing
    assign load    = stop_ok && !(o_valid && !i_ready);  // Holding reg free this clock

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= i_rxd;
            rxd_sync <= rxd_meta;
        end
    end

    // Bit timing FSM
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state    <= term_pkg::RX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            case (state)
                term_pkg::RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rxd_sync)
                        state <= term_pkg::RX_START;  // Falling edge
                end
                term_pkg::RX_START: begin
                    if (mid_bit) begin
                        tick_cnt <= '0;               // Re-align to bit centre
                        bit_idx  <= '0;
                        // Line back high at mid-bit means a glitch
                        state    <= rxd_sync ? term_pkg::RX_IDLE : term_pkg::RX_DATA;
                    end
                end
                term_pkg::RX_DATA: begin
                    if (end_bit) begin
                        tick_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= term_pkg::RX_STOP;
                    end
                end
                term_pkg::RX_STOP: begin
                    if (end_bit)
                        state <= term_pkg::RX_IDLE;  // Low stop bit just drops the byte
                end
                default: state <= term_pkg::RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == term_pkg::RX_DATA && end_bit)
            shift_reg <= {rxd_sync, shift_reg[7:1]};  // LSB first on the wire
    end

    // Holding register hand-off
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid   <= 1'b0;
            o_overrun <= 1'b0;
        end else begin
            o_overrun <= stop_ok && !load;
            if (o_valid && i_ready)
                o_valid <= 1'b0;
            if (load)
                o_valid <= 1'b1;   // Wins over the transfer clear
        end
    end

    always_ff @(posedge i_clk) begin
        if (load)
            o_char <= shift_reg;
    end

    // Held byte must not change under back-pressure
    a_char_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_valid && !i_ready |=> $stable(o_char));

endmodule

`default_nettype wire

//--- design/char_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module char_ctrl (
    input  wire logic             i_clk,
    input  wire logic             i_arst_n,
    input  wire logic             i_valid,
    input  wire term_pkg::char_t  i_char,
    input  wire logic             i_ectlchrs,  // Draw control codes as glyphs
    output logic                  o_ready,
    output logic                  o_wr_en,
    output term_pkg::vram_addr_t  o_wr_addr,
    output term_pkg::char_t       o_wr_char,
    output term_pkg::row_t        o_top_row,   // Physical row shown on top
    output logic                  o_bell
);

    typedef logic [$clog2(term_pkg::BELL_CYCLES + 1)-1:0] bell_cnt_t;

    term_pkg::ctrl_state_t state;
    term_pkg::col_t        cur_col;    // Screen coordinates
    term_pkg::row_t        cur_row;
    term_pkg::row_t        phys_row;   // Cursor row in RAM
    term_pkg::row_t        bot_row;    // Physical bottom row
    term_pkg::vram_addr_t  clr_cnt;    // Cell counter for both clears
    term_pkg::char_t       pend_char;  // Accepted glyph awaiting write
    bell_cnt_t             bell_cnt;
    logic                  armed;      // Low for the first clock out of reset
    logic                  accept;
    logic                  is_glyph;
    logic                  last_col;
    logic                  last_row;
    logic                  line_feed;  // Cursor steps down this clock

    assign o_ready   = (state == term_pkg::CT_IDLE);
    assign accept    = i_valid && o_ready;
    assign last_col  = (cur_col == term_pkg::col_t'(term_pkg::COLS - 1));
    assign last_row  = (cur_row == term_pkg::row_t'(term_pkg::ROWS - 1));
    assign phys_row  = cur_row + o_top_row;  // Wraps modulo ROWS
    assign bot_row   = o_top_row - 1'b1;     // Row just above the top
    assign o_bell    = (bell_cnt != '0);
    assign o_wr_en   = armed && (state != term_pkg::CT_IDLE);

    // Explicit LF, or wrap after the last column
    assign line_feed = (accept && !is_glyph && i_char == 8'h0A) ||
                       (state == term_pkg::CT_WRITE && last_col);

    always_comb begin
        case (i_char)
            8'h07, 8'h08, 8'h0A, 8'h0D: is_glyph = 1'b0;  // BEL BS LF CR always act
            default: is_glyph = (i_char >= 8'h20 && i_char < 8'h7F) ||
                                ((i_char < 8'h20 || i_char == 8'h7F) && i_ectlchrs);
        endcase
    end

    // RAM write port mux
    always_comb begin
        case (state)
            term_pkg::CT_WRITE: begin
                o_wr_addr = {phys_row, cur_col};
                o_wr_char = pend_char;
            end
            term_pkg::CT_CLEAR_ROW: begin
                o_wr_addr = {bot_row, term_pkg::col_t'(clr_cnt)};
                o_wr_char = term_pkg::CLEAR_CHAR;
            end
            default: begin
                o_wr_addr = clr_cnt;                 // Whole-screen sweep
                o_wr_char = term_pkg::CLEAR_CHAR;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state     <= term_pkg::CT_CLEAR_ALL;
            armed     <= 1'b0;
            clr_cnt   <= '0;
            cur_col   <= '0;
            cur_row   <= '0;
            o_top_row <= '0;
        end else begin
            armed <= 1'b1;
            case (state)
                term_pkg::CT_CLEAR_ALL: begin
                    if (armed) begin
                        clr_cnt <= clr_cnt + 1'b1;
                        if (clr_cnt == term_pkg::vram_addr_t'(term_pkg::COLS * term_pkg::ROWS - 1))
                            state <= term_pkg::CT_IDLE;
                    end
                end
                term_pkg::CT_IDLE: begin
                    if (accept && is_glyph) begin
                        state <= term_pkg::CT_WRITE;
                    end else if (accept && i_char == 8'h0D) begin
                        cur_col <= '0;                    // CR
                    end else if (accept && i_char == 8'h08 && cur_col != '0) begin
                        cur_col <= cur_col - 1'b1;        // BS stops at column 0
                    end
                end
                term_pkg::CT_WRITE: begin
                    state   <= term_pkg::CT_IDLE;
                    cur_col <= last_col ? '0 : cur_col + 1'b1;
                end
                term_pkg::CT_CLEAR_ROW: begin
                    clr_cnt <= clr_cnt + 1'b1;
                    if (term_pkg::col_t'(clr_cnt) == term_pkg::col_t'(term_pkg::COLS - 1))
                        state <= term_pkg::CT_IDLE;
                end
                default: state <= term_pkg::CT_IDLE;
            endcase

            if (line_feed) begin
                if (last_row) begin
                    o_top_row <= o_top_row + 1'b1;  // Scroll, old top becomes bottom
                    clr_cnt   <= '0;
                    state     <= term_pkg::CT_CLEAR_ROW;
                end else begin
                    cur_row <= cur_row + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept)
            pend_char <= i_char;
    end

    // Bell timer
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n)
            bell_cnt <= '0;
        else if (accept && i_char == 8'h07)
            bell_cnt <= bell_cnt_t'(term_pkg::BELL_CYCLES);  // Retrigger restarts it
        else if (o_bell)
            bell_cnt <= bell_cnt - 1'b1;
    end

    a_idle_no_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        state == term_pkg::CT_IDLE |-> !o_wr_en);

    a_ready_only_idle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_ready |-> state == term_pkg::CT_IDLE);

endmodule

`default_nettype wire

//--- design/text_vram.sv
`timescale 1ns/1ns
`default_nettype none

module text_vram (
    input  wire logic                  i_clk,
    // Controller side
    input  wire logic                  i_wr_en,
    input  wire term_pkg::vram_addr_t  i_wr_addr,
    input  wire term_pkg::char_t       i_wr_char,
    // Scanner side
    input  wire term_pkg::vram_addr_t  i_rd_addr,
    output term_pkg::char_t            o_rd_char   // One clock after address
);

    // One code per cell, {row, col} addressing
    term_pkg::char_t mem [0:term_pkg::COLS * term_pkg::ROWS - 1];

    always_ff @(posedge i_clk) begin
        if (i_wr_en)
            mem[i_wr_addr] <= i_wr_char;
    end

    // Registered read, old data on a same-cell collision
    always_ff @(posedge i_clk) begin
        o_rd_char <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

//--- design/video_scan.sv
`timescale 1ns/1ns
`default_nettype none

module video_scan (
    input  wire logic                  i_clk,
    input  wire logic                  i_arst_n,
    input  wire term_pkg::row_t        i_top_row,
    input  wire logic                  i_bell,       // Reverse video
    output term_pkg::vram_addr_t       o_rd_addr,
    input  wire term_pkg::char_t       i_rd_char,
    output term_pkg::font_addr_t       o_font_addr,
    input  wire term_pkg::font_row_t   i_font_row,   // One clock after address
    output term_pkg::lcd_out_t         o_lcd
);

    typedef logic [$clog2(term_pkg::H_TOTAL)-1:0] hcnt_t;
    typedef logic [$clog2(term_pkg::V_TOTAL)-1:0] vcnt_t;
    typedef logic [$clog2(term_pkg::GLYPH_W)-1:0] px_t;
    typedef logic [$clog2(term_pkg::GLYPH_H)-1:0] line_t;

    // Per-pixel info carried alongside the fetches
    typedef struct packed {
        px_t   px;      // Bit within glyph row
        line_t line;    // Glyph line
        logic  active;
        logic  hsync;
        logic  vsync;
    } pipe_t;

    hcnt_t          hcnt;
    vcnt_t          vcnt;
    term_pkg::row_t cell_row;  // Physical text row
    term_pkg::col_t cell_col;
    pipe_t          s0;        // Raster counters
    pipe_t          s1;        // RAM data valid
    pipe_t          s2;        // Font data valid
    logic           pix;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == hcnt_t'(term_pkg::H_TOTAL - 1)) begin
            hcnt <= '0;
            vcnt <= (vcnt == vcnt_t'(term_pkg::V_TOTAL - 1)) ? '0 : vcnt + 1'b1;
        end else begin
            hcnt <= hcnt + 1'b1;
        end
    end

    // Stage 1 source, counters to RAM address
    always_comb begin
        s0.px     = px_t'(hcnt);
        s0.line   = line_t'(vcnt);
        s0.active = (hcnt < hcnt_t'(term_pkg::H_ACTIVE)) && (vcnt < vcnt_t'(term_pkg::V_ACTIVE));
        s0.hsync  = (hcnt >= hcnt_t'(term_pkg::H_SYNC_START)) &&
                    (hcnt <  hcnt_t'(term_pkg::H_SYNC_START + term_pkg::H_SYNC_LEN));
        s0.vsync  = (vcnt >= vcnt_t'(term_pkg::V_SYNC_START)) &&
                    (vcnt <  vcnt_t'(term_pkg::V_SYNC_START + term_pkg::V_SYNC_LEN));
    end

    assign cell_col  = term_pkg::col_t'(hcnt >> $clog2(term_pkg::GLYPH_W));
    assign cell_row  = term_pkg::row_t'(vcnt >> $clog2(term_pkg::GLYPH_H)) + i_top_row;
    assign o_rd_addr = {cell_row, cell_col};

    // Stage 2 source, RAM data to font address
    assign o_font_addr = {i_rd_char, s1.line};

    // Glyph bit for this pixel, MSB first
    assign pix = s2.active && (i_font_row[~s2.px] ^ i_bell);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            s1    <= '0;
            s2    <= '0;
            o_lcd <= '0;
        end else begin
            s1          <= s0;
            s2          <= s1;
            o_lcd.rgb   <= {$bits(term_pkg::rgb_t){pix}};  // FFFF fg, 0000 bg
            o_lcd.hsync <= s2.hsync;
            o_lcd.vsync <= s2.vsync;
            o_lcd.den   <= s2.active;
        end
    end

    a_den_blank: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_lcd.den |-> !(o_lcd.hsync || o_lcd.vsync));

endmodule

`default_nettype wire

//--- design/terminal_top.sv
`timescale 1ns/1ns
`default_nettype none

module terminal_top (
    input  wire logic                 i_clk,
    input  wire logic                 i_arst_n,
    input  wire logic                 i_rxd,
    input  wire logic                 i_ectlchrs,
    output term_pkg::font_addr_t      o_font_addr,  // To external font ROM
    input  wire term_pkg::font_row_t  i_font_row,
    output term_pkg::lcd_out_t        o_lcd,
    output logic                      o_overrun
);

    logic                 rx_valid;
    logic                 rx_ready;
    term_pkg::char_t      rx_char;
    logic                 wr_en;
    term_pkg::vram_addr_t wr_addr;
    term_pkg::char_t      wr_char;
    term_pkg::vram_addr_t rd_addr;
    term_pkg::char_t      rd_char;
    term_pkg::row_t       top_row;   // Scroll offset
    logic                 bell;

    serial_rx u_rx (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_rxd     (i_rxd),
        .i_ready   (rx_ready),
        .o_valid   (rx_valid),
        .o_char    (rx_char),
        .o_overrun (o_overrun)
    );

    char_ctrl u_ctrl (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_valid    (rx_valid),
        .i_char     (rx_char),
        .i_ectlchrs (i_ectlchrs),
        .o_ready    (rx_ready),
        .o_wr_en    (wr_en),
        .o_wr_addr  (wr_addr),
        .o_wr_char  (wr_char),
        .o_top_row  (top_row),
        .o_bell     (bell)
    );

    text_vram u_vram (
        .i_clk     (i_clk),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_char (wr_char),
        .i_rd_addr (rd_addr),
        .o_rd_char (rd_char)
    );

    video_scan u_scan (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_top_row   (top_row),
        .i_bell      (bell),
        .o_rd_addr   (rd_addr),
        .i_rd_char   (rd_char),
        .o_font_addr (o_font_addr),
        .i_font_row  (i_font_row),
        .o_lcd       (o_lcd)
    );

endmodule

`default_nettype wire

//--- tb/terminal_tb_tasks.svh
`ifndef TERMINAL_TB_TASKS_SVH
`define TERMINAL_TB_TASKS_SVH

// 8N1 frame LSB first, then one idle bit time
task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
        @(posedge clk);
        #2 rxd = (i < 10) ? frame[i] : 1'b1;
        repeat (BIT_CLKS - 1) @(posedge clk);
    end
endtask

// Controller idle with nothing held in the receiver
task automatic wait_settle();
    int n;
    n = 0;
    @(negedge clk);
    while (!(uut.rx_ready && !uut.rx_valid) && n < 40 * BIT_CLKS) begin
        @(negedge clk);
        n++;
    end
    if (!(uut.rx_ready && !uut.rx_valid)) begin
        $display("ERROR %0t: controller never came back to idle", $time);
        timed_out = 1'b1;
    end
endtask

task automatic wait_vsync_rise();
    int   n;
    logic prev;
    logic rose;
    n    = 0;
    rose = 1'b0;
    prev = lcd.vsync;
    while (!rose && n < 2 * FRAME) begin
        @(negedge clk);
        rose = lcd.vsync && !prev;   // Sampled mid-cycle
        prev = lcd.vsync;
        n++;
    end
    if (!rose) begin
        $display("ERROR %0t: no vsync seen within two frames", $time);
        timed_out = 1'b1;
    end
endtask

// Den-qualified pixels in raster order
task automatic check_frame(input bit bell);
    int          n;
    int          idx;
    int          x;
    int          y;
    int          blank;     // Clocks since den fell, -1 before first den
    logic        want_hs;
    logic [15:0] want;
    n     = 0;
    idx   = 0;
    blank = -1;
    while (idx < term_pkg::H_ACTIVE * term_pkg::V_ACTIVE && n < 2 * FRAME) begin
        @(negedge clk);
        n++;
        if (lcd.den) begin
            blank = 0;
            x     = idx % term_pkg::H_ACTIVE;
            y     = idx / term_pkg::H_ACTIVE;
            want  = expected_rgb(x, y, bell);
            assert (lcd.rgb == want) else begin
                $display("FAIL %0t: pixel (%0d,%0d) expected %h got %h",
                         $time, x, y, want, lcd.rgb);
                test_errs++;
            end
            idx++;
        end else if (blank >= 0) begin
            blank++;
        end
        // Hsync sits in the line blanking, a fixed gap after the last active pixel
        want_hs = (blank >= 1 + term_pkg::H_SYNC_START - term_pkg::H_ACTIVE) &&
                  (blank <  1 + term_pkg::H_SYNC_START - term_pkg::H_ACTIVE +
                            term_pkg::H_SYNC_LEN);
        if (blank >= 0) begin
            assert (lcd.hsync == want_hs && !lcd.vsync) else begin
                $display("FAIL %0t: after pixel %0d expected hsync %b vsync 0, got %b %b",
                         $time, idx, want_hs, lcd.hsync, lcd.vsync);
                test_errs++;
            end
        end
    end
    if (idx < term_pkg::H_ACTIVE * term_pkg::V_ACTIVE) begin
        $display("ERROR %0t: frame ended after only %0d active pixels", $time, idx);
        timed_out = 1'b1;
    end
endtask

`endif

//--- tb/terminal_tb.sv
`timescale 1ns/1ns
`default_nettype none

module terminal_tb;

    localparam int NTESTS   = 10;
    localparam int BIT_CLKS = term_pkg::CLKS_PER_BIT;
    localparam int FRAME    = term_pkg::H_TOTAL * term_pkg::V_TOTAL;  // Clocks per frame

    logic                 clk;
    logic                 arst_n;
    logic                 rxd;
    logic                 ectlchrs;
    term_pkg::font_addr_t font_addr;
    term_pkg::font_addr_t font_addr_q;   // ROM address register
    term_pkg::font_row_t  font_row;
    term_pkg::lcd_out_t   lcd;
    logic                 overrun;

    logic [7:0]  shadow [0:term_pkg::ROWS-1][0:term_pkg::COLS-1];  // Screen coordinates
    int          cur_col;
    int          cur_row;
    logic [16:0] lfsr;
    int          test_errs;
    int          total_errs;
    int          n_clean;
    bit          timed_out;

    // Stimulus table, one entry per test
    string tbl_name  [NTESTS];
    string tbl_bytes [NTESTS];
    bit    tbl_ectl  [NTESTS];
    int    tbl_rand  [NTESTS];   // Random printable bytes appended
    int    tbl_idle  [NTESTS];   // Clocks to wait before sending
    bit    tbl_bell  [NTESTS];   // Reverse video expected

    terminal_top uut (
        .i_clk       (clk),
        .i_arst_n    (arst_n),
        .i_rxd       (rxd),
        .i_ectlchrs  (ectlchrs),
        .o_font_addr (font_addr),
        .i_font_row  (font_row),
        .o_lcd       (lcd),
        .o_overrun   (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Code XOR line times 11h
    function automatic term_pkg::font_row_t glyph_row(input term_pkg::font_addr_t a);
        return a[10:3] ^ ({5'd0, a[2:0]} * 8'h11);
    endfunction

    // External font ROM, one clock read latency
    always @(posedge clk) begin
        font_addr_q = font_addr;
        #2 font_row = glyph_row(font_addr_q);
    end

    function automatic logic [15:0] expected_rgb(input int x, input int y, input bit bell);
        term_pkg::font_row_t g;
        g = glyph_row({shadow[y / term_pkg::GLYPH_H][x / term_pkg::GLYPH_W], y[2:0]});
        return {16{g[7 - (x % term_pkg::GLYPH_W)] ^ bell}};  // MSB is leftmost
    endfunction

    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};  // x^17 + x^14 + 1
    endfunction

    // 7 LFSR bits folded into 20h..7Eh
    task automatic random_printable(output logic [7:0] b);
        logic [6:0] v;
        v = '0;
        for (int i = 0; i < 7; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[5:0], lfsr[0]};
        end
        b = 8'h20 + (v % 95);
    endtask

    task automatic line_feed();
        if (cur_row == term_pkg::ROWS - 1) begin
            for (int r = 0; r < term_pkg::ROWS - 1; r++)
                for (int c = 0; c < term_pkg::COLS; c++)
                    shadow[r][c] = shadow[r + 1][c];           // Scroll up
            for (int c = 0; c < term_pkg::COLS; c++)
                shadow[term_pkg::ROWS - 1][c] = 8'h20;         // Blank bottom row
        end else begin
            cur_row++;
        end
    endtask

    task automatic model_byte(input logic [7:0] b, input bit ectl);
        bit glyph;
        glyph = (b >= 8'h20 && b <= 8'h7E) ||
                (ectl && (b < 8'h20 || b == 8'h7F) &&
                 b != 8'h07 && b != 8'h08 && b != 8'h0A && b != 8'h0D);
        if (glyph) begin
            shadow[cur_row][cur_col] = b;
            if (cur_col == term_pkg::COLS - 1) begin
                cur_col = 0;   // Wrap
                line_feed();
            end else begin
                cur_col++;
            end
        end else if (b == 8'h0A) begin
            line_feed();
        end else if (b == 8'h0D) begin
            cur_col = 0;
        end else if (b == 8'h08 && cur_col > 0) begin
            cur_col--;
        end
    endtask

    task automatic set_row(input int i, input string name, input string bytes,
                           input bit ectl, input int nrand, input int idle, input bit bell);
        tbl_name[i]  = name;
        tbl_bytes[i] = bytes;
        tbl_ectl[i]  = ectl;
        tbl_rand[i]  = nrand;
        tbl_idle[i]  = idle;
        tbl_bell[i]  = bell;
    endtask

    `include "terminal_tb_tasks.svh"

    // Overrun must never fire
    always @(negedge clk) begin
        if (arst_n)
            assert (!overrun) else begin
                $display("FAIL %0t: receiver overrun, byte dropped", $time);
                test_errs++;
            end
    end

    initial begin : main
        string      s;
        logic [7:0] b;
        logic [7:0] q [$];
        rxd        = 1'b1;
        ectlchrs   = 1'b0;
        arst_n     = 1'b0;
        font_row   = '0;
        lfsr       = 17'd96593;
        cur_col    = 0;
        cur_row    = 0;
        test_errs  = 0;
        total_errs = 0;
        n_clean    = 0;
        timed_out  = 1'b0;
        for (int r = 0; r < term_pkg::ROWS; r++)
            for (int c = 0; c < term_pkg::COLS; c++)
                shadow[r][c] = 8'h20;

        //      name        bytes                                  ectl rand idle  bell
        set_row(0, "reset",    "",                                 0,   0,   0,    0);
        set_row(1, "text",     "Hello",                            0,   0,   0,    0);
        set_row(2, "cursor",   "\015AB\012\010\010\010Q\015\012",  0,   0,   0,    0);
        set_row(3, "wrap",     "0123456789ABCDEFwrap\012\012\012\012", 0, 0, 0,    0);
        set_row(4, "scroll",   "end\012abcdefghijklm",             0,   0,   0,    0);
        set_row(5, "ctl_off",  "\001\177x",                        0,   0,   0,    0);
        set_row(6, "ctl_on",   "\001\177",                         1,   0,   0,    0);
        set_row(7, "random",   "",                                 0,   12,  0,    0);
        set_row(8, "bell",     "\007",                             0,   0,   0,    1);
        set_row(9, "bell_end", "",                                 0,   0,
                term_pkg::BELL_CYCLES + FRAME, 0);

        repeat (3) @(posedge clk);
        #2 arst_n = 1'b1;

        for (int t = 0; t < NTESTS && !timed_out; t++) begin
            test_errs = 0;
            repeat (tbl_idle[t]) @(posedge clk);   // Let the bell run out
            @(posedge clk);
            #2 ectlchrs = tbl_ectl[t];
            s = tbl_bytes[t];
            q = {};
            for (int i = 0; i < s.len(); i++)
                q.push_back(s[i]);
            for (int i = 0; i < tbl_rand[t]; i++) begin
                random_printable(b);
                q.push_back(b);
            end
            foreach (q[i]) begin
                send_byte(q[i]);
                model_byte(q[i], tbl_ectl[t]);
            end
            wait_settle();
            if (!timed_out)
                wait_vsync_rise();
            if (!timed_out)
                check_frame(tbl_bell[t]);
            if (test_errs == 0 && !timed_out)
                n_clean++;
            total_errs += test_errs;
            $display("test %-8s %s, %0d errors", tbl_name[t],
                     (test_errs == 0 && !timed_out) ? "ok" : "bad", test_errs);
        end

        $display("%0d of %0d tests clean, %0d errors", n_clean, NTESTS, total_errs);
        if (total_errs == 0 && !timed_out && n_clean == NTESTS)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- terminal.f
+incdir+tb
design/term_pkg.sv
design/serial_rx.sv
design/char_ctrl.sv
design/text_vram.sv
design/video_scan.sv
design/terminal_top.sv
tb/terminal_tb.sv
